// File: Makefile
# Verilator build, run, lint and clean for the processor testbench

VERILATOR ?= verilator
TOP       ?= thiele_cpu_tb
RTL_TOP   ?= thiele_cpu
FILELIST  ?= thiele_cpu.f
MDIR      ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing
PASS_MSG  := *** TEST PASSED ***
FAIL_MSG  := *** TEST FAILED ***

.PHONY: all build run lint clean

all: run

build: $(MDIR)/V$(TOP)

$(MDIR)/V$(TOP): $(FILELIST) $(wildcard src/*.sv) $(wildcard bench/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(MDIR) -f $(FILELIST)

run: build
	./$(MDIR)/V$(TOP) | tee $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then echo "No result in $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(MDIR) $(LOG)

// File: bench/thiele_cases.txt
// instr    reply    status   error    cert     part_ops info_gain pc   (hex, one case per line)
// Rank on reset matrix, loads, add, swap, then rank again
0D000000 00000000 00000002 00000000 00000000 00000000 00000000 00000004
0A004100 00000000 00000007 00000000 00000000 00000000 00000000 00000008
0A010100 00000000 00000007 00000000 00000000 00000000 00000000 0000000C
0D000000 00000000 00000003 00000000 00000000 00000000 00000000 00000010
0B000300 00000000 00000008 00000000 00000000 00000001 00000000 00000014
0D000000 00000000 00000002 00000000 00000000 00000001 00000000 00000018
0C000100 00000000 00000009 00000000 00000000 00000002 00000000 0000001C
0B030300 00000000 00000008 00000000 00000000 00000003 00000000 00000020
0D000000 00000000 00000001 00000000 00000000 00000003 00000000 00000024
// Bad rows on add, swap and load
0B040000 00000000 00000001 0000000A 00000000 00000003 00000000 00000028
0C000700 00000000 00000001 0000000B 00000000 00000003 00000000 0000002C
0AFF4100 00000000 00000001 0000000C 00000000 00000003 00000000 00000030
0D000000 00000000 00000001 0000000C 00000000 00000003 00000000 00000034
// Gain updates, engine queries and certificate join
0E002A00 00000000 002A0000 0000000C 00000000 00000003 0000002A 00000038
0E030500 00000000 03050000 0000000C 00000000 00000003 0000002B 0000003C
0E010000 00000000 01000000 0000000C 00000000 00000003 0000002C 00000040
03123400 DEADBEEF 01000000 0000000C DEADBEEF 00000003 0000002C 00000044
04567800 00000000 00000004 0000000C 56780000 00000003 0000002C 00000048
03A55A00 0BADF00D 00000004 0000000C 0BADF00D 00000003 0000002C 0000004C
// Dropped opcodes, then matrix and gain again
00000000 00000000 00000004 00000001 0BADF00D 00000003 0000002C 00000050
05112200 00000000 00000004 00000001 0BADF00D 00000003 0000002C 00000054
08010200 00000000 00000004 00000001 0BADF00D 00000003 0000002C 00000058
0A033F00 00000000 00000007 00000001 0BADF00D 00000003 0000002C 0000005C
0D000000 00000000 00000002 00000001 0BADF00D 00000003 0000002C 00000060
0E000000 00000000 00000000 00000001 0BADF00D 00000003 00000000 00000064

// File: bench/thiele_cpu_tb.sv
// ==========================================================================
// Testbench: clock, reset, Wishbone slave models, case replay and watchdog
// ==========================================================================

`timescale 1ns/1ps

module thiele_cpu_tb;

    // ======================================================================
    // Constants, DUT wiring and case storage
    // ======================================================================

    localparam int          MAX_CASES       = 64;
    localparam int          CASE_COLS       = 8;
    localparam int          CASE_WORDS      = MAX_CASES * CASE_COLS;
    localparam int          CYCLES_PER_CASE = 12;
    localparam int          SETTLE_CYCLES   = 20;
    localparam logic [31:0] LFSR_SEED       = 32'h544f_bf6c;

    logic                 clk;
    logic                 rst_n;
    thiele_pkg::wb_req_t  ibus;
    logic                 ibus_ack;
    thiele_pkg::word_t    ibus_dat;
    thiele_pkg::wb_req_t  lbus;
    logic                 lbus_ack;
    thiele_pkg::word_t    lbus_dat;
    thiele_pkg::word_t    pc;
    thiele_pkg::word_t    status;
    thiele_pkg::word_t    error_code;
    thiele_pkg::word_t    cert_addr;
    thiele_pkg::word_t    partition_ops;
    thiele_pkg::word_t    info_gain;

    // Columns: instr, reply, status, error, cert, part ops, gain, pc
    thiele_pkg::word_t cases [0:CASE_WORDS-1];
    int          num_cases;
    bit          loaded;
    logic [31:0] lfsr;
    string       label;
    int          case_errs;
    int          tests_run;
    int          failed_tests;
    int          other_fails;

    thiele_cpu UUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .ibus          (ibus),
        .ibus_ack      (ibus_ack),
        .ibus_dat      (ibus_dat),
        .lbus          (lbus),
        .lbus_ack      (lbus_ack),
        .lbus_dat      (lbus_dat),
        .pc            (pc),
        .status        (status),
        .error_code    (error_code),
        .cert_addr     (cert_addr),
        .partition_ops (partition_ops),
        .info_gain     (info_gain)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ======================================================================
    // Helpers
    // ======================================================================

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Marks words the case file never wrote
    function automatic thiele_pkg::word_t fill_word(input int k);
        return 32'hF1A7_0000 ^ thiele_pkg::word_t'(k);
    endfunction

    // Inputs change 1 ns after the edge
    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    // Ack delay of 0 to 3 cycles, one LFSR step per bit
    task automatic stall_ack();
        int d;
        d = 0;
        for (int k = 0; k < 2; k++) begin
            lfsr = lfsr_next(lfsr);
            d = (d << 1) | int'(lfsr[0]);
        end
        repeat (d) step_cycle();
    endtask

    task automatic wait_ibus_request();
        while (ibus.stb !== 1'b1) step_cycle();
    endtask

    task automatic wait_lbus_request();
        while (lbus.stb !== 1'b1) step_cycle();
    endtask

    task automatic check_word(input string what, input thiele_pkg::word_t got,
                              input thiele_pkg::word_t exp);
        if (got !== exp) begin
            $display("ERR %0t: %s %s is %08h, expected %08h", $time, label, what, got, exp);
            case_errs++;
        end
    endtask

    task automatic report_test(input thiele_pkg::word_t instr);
        tests_run++;
        if (case_errs == 0) begin
            $display("%s instr %08h: pass", label, instr);
        end else begin
            $display("%s instr %08h: fail with %0d mismatches", label, instr, case_errs);
            failed_tests++;
        end
        case_errs = 0;
    endtask

    // Outputs are final once the next fetch request is up
    task automatic finish_case(input int idx);
        int base;
        base = idx * CASE_COLS;
        check_word("status", status, cases[base+2]);
        check_word("error_code", error_code, cases[base+3]);
        check_word("cert_addr", cert_addr, cases[base+4]);
        check_word("partition_ops", partition_ops, cases[base+5]);
        check_word("info_gain", info_gain, cases[base+6]);
        check_word("pc", pc, cases[base+7]);
        report_test(cases[base]);
    endtask

    // ======================================================================
    // Case replay, ibus and lbus slave models
    // ======================================================================

    task automatic run_cases();
        thiele_pkg::word_t instr;
        thiele_pkg::word_t exp_adr;
        for (int i = 0; i < num_cases; i++) begin
            instr = cases[i*CASE_COLS];
            wait_ibus_request();
            if (i > 0) begin
                finish_case(i - 1);
            end
            label = $sformatf("case %0d", i);
            check_word("fetch address", ibus.adr, thiele_pkg::PC_STEP * thiele_pkg::word_t'(i));
            stall_ack();
            ibus_dat = instr;
            ibus_ack = 1'b1;
            step_cycle();
            ibus_ack = 1'b0;
            ibus_dat = '0;
            // Engine query carries both operands in the low half
            if (instr[31:24] == thiele_pkg::LASSERT) begin
                wait_lbus_request();
                exp_adr = {16'd0, instr[23:8]};
                check_word("logic address", lbus.adr, exp_adr);
                stall_ack();
                lbus_dat = cases[i*CASE_COLS+1];
                lbus_ack = 1'b1;
                step_cycle();
                lbus_ack = 1'b0;
                lbus_dat = '0;
            end
        end
        wait_ibus_request();
        finish_case(num_cases - 1);
        $display("Fetch at %08h is past the last case, replay ends", ibus.adr);
    endtask

    initial begin
        rst_n        = 1'b0;
        ibus_ack     = 1'b0;
        ibus_dat     = '0;
        lbus_ack     = 1'b0;
        lbus_dat     = '0;
        lfsr         = LFSR_SEED;
        label        = "reset";
        case_errs    = 0;
        tests_run    = 0;
        failed_tests = 0;
        other_fails  = 0;
        for (int k = 0; k < CASE_WORDS; k++) begin
            cases[k] = fill_word(k);
        end
        $readmemh("bench/thiele_cases.txt", cases);
        num_cases = 0;
        while (num_cases < MAX_CASES &&
               cases[num_cases*CASE_COLS] != fill_word(num_cases*CASE_COLS)) begin
            num_cases++;
        end
        loaded = 1'b1;
        if (num_cases == 0) begin
            $display("No cases could be read from bench/thiele_cases.txt");
            other_fails++;
        end

        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // Cleared state and both buses idle
        check_word("status", status, '0);
        check_word("error_code", error_code, '0);
        check_word("cert_addr", cert_addr, '0);
        check_word("partition_ops", partition_ops, '0);
        check_word("info_gain", info_gain, '0);
        check_word("pc", pc, '0);
        check_word("bus cyc and stb", {28'd0, ibus.cyc, ibus.stb, lbus.cyc, lbus.stb}, '0);
        report_test('0);

        if (num_cases > 0) begin
            run_cases();
        end

        $display("Tests %0d, failed %0d, other failures %0d",
                 tests_run, failed_tests, other_fails);
        if (failed_tests == 0 && other_fails == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Worst case per instruction is about 11 cycles
    initial begin
        wait (loaded);
        repeat (num_cases * CYCLES_PER_CASE + SETTLE_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the DUT stopped making progress",
                 num_cases * CYCLES_PER_CASE + SETTLE_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: src/thiele_control.sv
// ==========================================================================
// Sequencer FSM, program counter, decode and both Wishbone masters
// ==========================================================================

`timescale 1ns/1ps

module thiele_control (
    input  logic                  clk,
    input  logic                  rst_n,
    output thiele_pkg::wb_req_t   ibus,
    input  logic                  ibus_ack,
    input  thiele_pkg::word_t     ibus_dat,
    output thiele_pkg::wb_req_t   lbus,
    input  logic                  lbus_ack,
    input  thiele_pkg::word_t     lbus_dat,
    output thiele_pkg::word_t     pc,
    output thiele_pkg::xor_cmd_t  xor_cmd,
    output thiele_pkg::csr_upd_t  csr_upd
);

    thiele_pkg::seq_state_t state;
    thiele_pkg::instr_t     instr;
    thiele_pkg::word_t      pc_q;
    logic                   ibus_cyc;
    logic                   lbus_cyc;

    // cyc and stb always move together
    assign ibus = '{cyc: ibus_cyc, stb: ibus_cyc, adr: pc_q};
    assign lbus = '{cyc: lbus_cyc, stb: lbus_cyc, adr: {16'd0, instr.a, instr.b}};
    assign pc   = pc_q;

    // ======================================================================
    // Sequencer
    // ======================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= thiele_pkg::FETCH;
            pc_q     <= '0;
            ibus_cyc <= 1'b0;
            lbus_cyc <= 1'b0;
        end else begin
            case (state)
                thiele_pkg::FETCH: begin
                    // Idle cycle first, then hold the request until ack
                    if (!ibus_cyc) begin
                        ibus_cyc <= 1'b1;
                    end else if (ibus_ack) begin
                        ibus_cyc <= 1'b0;
                        state    <= thiele_pkg::DECODE;
                    end
                end
                thiele_pkg::DECODE: begin
                    state <= thiele_pkg::EXECUTE;
                end
                thiele_pkg::EXECUTE: begin
                    if (instr.opcode == thiele_pkg::LASSERT) begin
                        lbus_cyc <= 1'b1;
                        state    <= thiele_pkg::LOGIC;
                    end else begin
                        pc_q  <= pc_q + thiele_pkg::PC_STEP;
                        state <= thiele_pkg::FETCH;
                    end
                end
                thiele_pkg::LOGIC: begin
                    // Logic engine may stall for any time
                    if (lbus_ack) begin
                        lbus_cyc <= 1'b0;
                        pc_q     <= pc_q + thiele_pkg::PC_STEP;
                        state    <= thiele_pkg::FETCH;
                    end
                end
                default: begin
                    state <= thiele_pkg::FETCH;
                end
            endcase
        end
    end

    // Fetched word, latched on the ack edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr <= '0;
        end else if (state == thiele_pkg::FETCH && ibus_cyc && ibus_ack) begin
            instr <= thiele_pkg::instr_t'(ibus_dat);
        end
    end

    // ======================================================================
    // Execute decode
    // ======================================================================

    always_comb begin
        xor_cmd   = '0;
        xor_cmd.a = instr.a;
        xor_cmd.b = instr.b;
        csr_upd   = '0;
        csr_upd.a = instr.a;
        csr_upd.b = instr.b;
        if (state == thiele_pkg::EXECUTE) begin
            case (instr.opcode)
                // Row checks live in the matrix unit
                thiele_pkg::XOR_LOAD: begin
                    xor_cmd.valid = 1'b1;
                    xor_cmd.op    = thiele_pkg::XOP_LOAD;
                end
                thiele_pkg::XOR_ADD: begin
                    xor_cmd.valid = 1'b1;
                    xor_cmd.op    = thiele_pkg::XOP_ADD;
                end
                thiele_pkg::XOR_SWAP: begin
                    xor_cmd.valid = 1'b1;
                    xor_cmd.op    = thiele_pkg::XOP_SWAP;
                end
                thiele_pkg::XOR_RANK: begin
                    xor_cmd.valid = 1'b1;
                    xor_cmd.op    = thiele_pkg::XOP_RANK;
                end
                thiele_pkg::EMIT: begin
                    csr_upd.status_we = 1'b1;
                    csr_upd.status    = {instr.a, instr.b, 16'd0};
                    csr_upd.emit      = 1'b1;
                end
                thiele_pkg::LJOIN: begin
                    csr_upd.status_we = 1'b1;
                    csr_upd.status    = thiele_pkg::ST_LJOIN;
                    csr_upd.cert_we   = 1'b1;
                    csr_upd.cert      = {instr.a, instr.b, 16'd0};
                end
                // Handled in LOGIC
                thiele_pkg::LASSERT: begin
                end
                default: begin
                    csr_upd.err_we = 1'b1;
                    csr_upd.err    = thiele_pkg::ERR_OPCODE;
                end
            endcase
        end else if (state == thiele_pkg::LOGIC && lbus_ack) begin
            // Certificate from the engine reply
            csr_upd.cert_we = 1'b1;
            csr_upd.cert    = lbus_dat;
        end
    end

    // ======================================================================
    // Checks
    // ======================================================================

    // Request and address held until the slave acks
    a_ibus_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ibus.stb && !ibus_ack |=> ibus.cyc && ibus.stb && $stable(ibus.adr));

    a_lbus_hold: assert property (@(posedge clk) disable iff (!rst_n)
        lbus.stb && !lbus_ack |=> lbus.cyc && lbus.stb && $stable(lbus.adr));

    a_one_bus: assert property (@(posedge clk) disable iff (!rst_n)
        !(ibus.cyc && lbus.cyc));

    // Only legal steps between sequencer states
    a_state_order: assert property (@(posedge clk) disable iff (!rst_n)
        state != $past(state) |->
            (state == thiele_pkg::DECODE && $past(state) == thiele_pkg::FETCH) ||
            (state == thiele_pkg::EXECUTE && $past(state) == thiele_pkg::DECODE) ||
            (state == thiele_pkg::LOGIC && $past(state) == thiele_pkg::EXECUTE) ||
            (state == thiele_pkg::FETCH &&
             $past(state) inside {thiele_pkg::EXECUTE, thiele_pkg::LOGIC}));

endmodule

// File: src/thiele_cpu.sv
// ==========================================================================
// Processor top level: sequencer, GF(2) matrix and register block
// ==========================================================================

`timescale 1ns/1ps

module thiele_cpu (
    input  logic                 clk,
    input  logic                 rst_n,

    // Instruction fetch port
    output thiele_pkg::wb_req_t  ibus,
    input  logic                 ibus_ack,
    input  thiele_pkg::word_t    ibus_dat,

    // Logic engine port
    output thiele_pkg::wb_req_t  lbus,
    input  logic                 lbus_ack,
    input  thiele_pkg::word_t    lbus_dat,

    // Architectural state
    output thiele_pkg::word_t    pc,
    output thiele_pkg::word_t    status,
    output thiele_pkg::word_t    error_code,
    output thiele_pkg::word_t    cert_addr,
    output thiele_pkg::word_t    partition_ops,
    output thiele_pkg::word_t    info_gain
);

    thiele_pkg::xor_cmd_t  xor_cmd;
    thiele_pkg::xor_resp_t xor_resp;
    thiele_pkg::csr_upd_t  csr_upd;

    // Sequencer and both bus masters
    thiele_control u_control (
        .clk      (clk),
        .rst_n    (rst_n),
        .ibus     (ibus),
        .ibus_ack (ibus_ack),
        .ibus_dat (ibus_dat),
        .lbus     (lbus),
        .lbus_ack (lbus_ack),
        .lbus_dat (lbus_dat),
        .pc       (pc),
        .xor_cmd  (xor_cmd),
        .csr_upd  (csr_upd)
    );

    // Row matrix, answers one clock after the command
    xor_matrix_unit u_xor (
        .clk      (clk),
        .rst_n    (rst_n),
        .xor_cmd  (xor_cmd),
        .xor_resp (xor_resp)
    );

    thiele_csr u_csr (
        .clk           (clk),
        .rst_n         (rst_n),
        .csr_upd       (csr_upd),
        .xor_resp      (xor_resp),
        .status        (status),
        .error_code    (error_code),
        .cert_addr     (cert_addr),
        .partition_ops (partition_ops),
        .info_gain     (info_gain)
    );

endmodule

// File: src/thiele_csr.sv
// ==========================================================================
// Status, error and certificate registers, partition and gain counters
// ==========================================================================

`timescale 1ns/1ps

module thiele_csr (
    input  logic                   clk,
    input  logic                   rst_n,
    input  thiele_pkg::csr_upd_t   csr_upd,
    input  thiele_pkg::xor_resp_t  xor_resp,
    output thiele_pkg::word_t      status,
    output thiele_pkg::word_t      error_code,
    output thiele_pkg::word_t      cert_addr,
    output thiele_pkg::word_t      partition_ops,
    output thiele_pkg::word_t      info_gain
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status        <= '0;
            error_code    <= '0;
            cert_addr     <= '0;
            partition_ops <= '0;
            info_gain     <= '0;
        end else begin
            // ==============================================================
            // Sequencer strobes
            // ==============================================================
            if (csr_upd.status_we) begin
                status <= csr_upd.status;
            end
            if (csr_upd.err_we) begin
                error_code <= csr_upd.err;
            end
            if (csr_upd.cert_we) begin
                cert_addr <= csr_upd.cert;
            end
            // Zero a loads the gain, otherwise count up
            if (csr_upd.emit) begin
                if (csr_upd.a == '0) begin
                    info_gain <= {24'd0, csr_upd.b};
                end else begin
                    info_gain <= info_gain + 32'd1;
                end
            end

            // ==============================================================
            // Matrix results, one cycle after EXECUTE
            // ==============================================================
            if (xor_resp.done) begin
                if (xor_resp.ok) begin
                    status <= xor_resp.code;
                end else begin
                    // Sticky until reset
                    error_code <= xor_resp.code;
                end
                if (xor_resp.count) begin
                    partition_ops <= partition_ops + 32'd1;
                end
            end
        end
    end

    // Sequencer and matrix never both write status in one cycle
    a_one_status_src: assert property (@(posedge clk) disable iff (!rst_n)
        !(csr_upd.status_we && xor_resp.done));

endmodule

// File: src/thiele_pkg.sv
// ==========================================================================
// Shared sizes, opcodes, status and error codes, and bus and
// command structs for the partition bookkeeping processor
// ==========================================================================

package thiele_pkg;

    // ======================================================================
    // Sizes and plain vectors
    // ======================================================================

    typedef logic [31:0] word_t;
    typedef logic [7:0]  operand_t;

    localparam int NUM_ROWS = 4;
    localparam int NUM_COLS = 6;

    typedef logic [NUM_COLS-1:0] xor_row_t;
    // Row count, 0 to NUM_ROWS
    typedef logic [2:0] rank_t;

    localparam word_t PC_STEP = 32'd4;

    // Matrix operation selector
    typedef logic [1:0] xor_op_t;
    localparam xor_op_t XOP_LOAD = 2'd0;
    localparam xor_op_t XOP_ADD  = 2'd1;
    localparam xor_op_t XOP_SWAP = 2'd2;
    localparam xor_op_t XOP_RANK = 2'd3;

    // ======================================================================
    // Enums
    // ======================================================================

    // Anything else decodes as unknown
    typedef enum logic [7:0] {
        LASSERT  = 8'h03,
        LJOIN    = 8'h04,
        XOR_LOAD = 8'h0A,
        XOR_ADD  = 8'h0B,
        XOR_SWAP = 8'h0C,
        XOR_RANK = 8'h0D,
        EMIT     = 8'h0E
    } opcode_t;

    typedef enum logic [1:0] {
        FETCH,
        DECODE,
        EXECUTE,
        LOGIC
    } seq_state_t;

    // Status values
    localparam word_t ST_LJOIN    = 32'd4;
    localparam word_t ST_XOR_LOAD = 32'd7;
    localparam word_t ST_XOR_ADD  = 32'd8;
    localparam word_t ST_XOR_SWAP = 32'd9;

    // Error values
    localparam word_t ERR_OPCODE    = 32'h1;
    localparam word_t ERR_ADD_ROWS  = 32'hA;
    localparam word_t ERR_SWAP_ROWS = 32'hB;
    localparam word_t ERR_LOAD_ROW  = 32'hC;

    // ======================================================================
    // Structs
    // ======================================================================

    typedef struct packed {
        opcode_t  opcode;
        operand_t a;
        operand_t b;
        logic [7:0] spare;
    } instr_t;

    // Master side of a Wishbone classic read port
    typedef struct packed {
        logic  cyc;
        logic  stb;
        word_t adr;
    } wb_req_t;

    typedef struct packed {
        logic     valid;
        xor_op_t  op;
        operand_t a;
        operand_t b;
    } xor_cmd_t;

    // Code holds the status on success and the error otherwise
    typedef struct packed {
        logic  done;
        logic  ok;
        logic  count;
        word_t code;
    } xor_resp_t;

    // One-cycle strobes from the sequencer to the register block
    typedef struct packed {
        logic     status_we;
        word_t    status;
        logic     err_we;
        word_t    err;
        logic     cert_we;
        word_t    cert;
        logic     emit;
        operand_t a;
        operand_t b;
    } csr_upd_t;

endpackage

// File: src/xor_matrix_unit.sv
// ==========================================================================
// GF(2) row matrix with parity: load, add, swap and rank
// ==========================================================================

`timescale 1ns/1ps

module xor_matrix_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  thiele_pkg::xor_cmd_t   xor_cmd,
    output thiele_pkg::xor_resp_t  xor_resp
);

    // Bit i of a row is column i
    thiele_pkg::xor_row_t [thiele_pkg::NUM_ROWS-1:0] rows;
    logic [thiele_pkg::NUM_ROWS-1:0]                 parity;

    logic [$clog2(thiele_pkg::NUM_ROWS)-1:0] row_a;
    logic [$clog2(thiele_pkg::NUM_ROWS)-1:0] row_b;
    logic                                    a_ok;
    logic                                    b_ok;
    thiele_pkg::rank_t                       ones;

    // Only this unit checks row indices
    assign a_ok  = xor_cmd.a < thiele_pkg::NUM_ROWS;
    assign b_ok  = xor_cmd.b < thiele_pkg::NUM_ROWS;
    assign row_a = xor_cmd.a[$clog2(thiele_pkg::NUM_ROWS)-1:0];
    assign row_b = xor_cmd.b[$clog2(thiele_pkg::NUM_ROWS)-1:0];

    // Simplified rank, rows with column 0 set
    always_comb begin
        ones = '0;
        for (int i = 0; i < thiele_pkg::NUM_ROWS; i++) begin
            ones = ones + thiele_pkg::rank_t'(rows[i][0]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // Starting pattern, row 3 down to row 0
            rows     <= {6'b000011, 6'b100100, 6'b010010, 6'b100101};
            parity   <= 4'b0110;
            xor_resp <= '0;
        end else begin
            xor_resp.done  <= xor_cmd.valid;
            xor_resp.ok    <= 1'b1;
            xor_resp.count <= 1'b0;
            xor_resp.code  <= '0;
            if (xor_cmd.valid) begin
                case (xor_cmd.op)
                    thiele_pkg::XOP_LOAD: begin
                        // Operand b carries the columns and parity at bit 6
                        if (a_ok) begin
                            rows[row_a]   <= xor_cmd.b[thiele_pkg::NUM_COLS-1:0];
                            parity[row_a] <= xor_cmd.b[thiele_pkg::NUM_COLS];
                            xor_resp.code <= thiele_pkg::ST_XOR_LOAD;
                        end else begin
                            xor_resp.ok   <= 1'b0;
                            xor_resp.code <= thiele_pkg::ERR_LOAD_ROW;
                        end
                    end
                    thiele_pkg::XOP_ADD: begin
                        if (a_ok && b_ok) begin
                            rows[row_a]    <= rows[row_a] ^ rows[row_b];
                            parity[row_a]  <= parity[row_a] ^ parity[row_b];
                            xor_resp.count <= 1'b1;
                            xor_resp.code  <= thiele_pkg::ST_XOR_ADD;
                        end else begin
                            xor_resp.ok   <= 1'b0;
                            xor_resp.code <= thiele_pkg::ERR_ADD_ROWS;
                        end
                    end
                    thiele_pkg::XOP_SWAP: begin
                        if (a_ok && b_ok) begin
                            rows[row_a]    <= rows[row_b];
                            rows[row_b]    <= rows[row_a];
                            parity[row_a]  <= parity[row_b];
                            parity[row_b]  <= parity[row_a];
                            xor_resp.count <= 1'b1;
                            xor_resp.code  <= thiele_pkg::ST_XOR_SWAP;
                        end else begin
                            xor_resp.ok   <= 1'b0;
                            xor_resp.code <= thiele_pkg::ERR_SWAP_ROWS;
                        end
                    end
                    default: begin
                        // Rank never fails and is not counted
                        xor_resp.code <= {29'd0, ones};
                    end
                endcase
            end
        end
    end

    // Bad row index leaves the whole matrix untouched
    a_no_bad_write: assert property (@(posedge clk) disable iff (!rst_n)
        xor_cmd.valid && xor_cmd.op != thiele_pkg::XOP_RANK &&
        !(a_ok && (b_ok || xor_cmd.op == thiele_pkg::XOP_LOAD))
        |=> $stable(rows) && $stable(parity));

endmodule

// File: thiele_cpu.f
src/thiele_pkg.sv
src/xor_matrix_unit.sv
src/thiele_csr.sv
src/thiele_control.sv
src/thiele_cpu.sv
bench/thiele_cpu_tb.sv
